//--- project.f
src/ir_rx_pkg.sv
src/sample_tick_gen.sv
src/ir_input_filter.sv
src/ir_frame_receiver.sv
src/ir_command_queue.sv
src/ir_remote_rx.sv
bench/ir_remote_rx_chk.sv
bench/ir_remote_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ir_remote_rx testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module ir_remote_rx_tb -f project.f -o ir_remote_rx_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/ir_remote_rx_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

//--- bench/ir_remote_rx_tb.sv
`timescale 1ns/1ns

module ir_remote_rx_tb;

	localparam int TICK_DIV = 4;
	localparam int QUEUE_DEPTH = 4;
	// low time after every mark, in ticks
	localparam int gap_ticks = 8;
	// fits neither data window
	localparam int bad_len = 12;
	localparam int wait_limit = 64 * TICK_DIV;

	logic clock = 1'b0;
	logic rst;
	logic ir_in;
	logic cmd_ready;
	logic cmd_valid;
	logic [ir_rx_pkg::cmd_bits-1:0] cmd_data;
	logic [ir_rx_pkg::stat_bits-1:0] drop_count;
	logic [ir_rx_pkg::stat_bits-1:0] error_count;

	// fibonacci lfsr, x^17 + x^14 + 1
	logic [16:0] lfsr_state = 17'd88364;
	// words seen leaving the DUT, in order
	logic [ir_rx_pkg::cmd_bits-1:0] got [$];
	// words sent in the current test
	logic [ir_rx_pkg::cmd_bits-1:0] sent [$];
	// expected counter values
	int exp_drop = 0;
	int exp_err = 0;

	ir_remote_rx #(
		.TICK_DIV(TICK_DIV),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) ir_remote_rx_i (
		.clock(clock),
		.rst(rst),
		.ir_in(ir_in),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_data(cmd_data),
		.drop_count(drop_count),
		.error_count(error_count)
	);

	always #4 clock = ~clock;

	// a transfer seen mid-cycle completes on the next rising edge
	always @(negedge clock) begin
		if (!rst && cmd_valid && cmd_ready) begin
			got.push_back(cmd_data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// one lfsr step per payload bit
	task automatic next_word(output logic [ir_rx_pkg::cmd_bits-1:0] w);
		for (int i = 0; i < ir_rx_pkg::cmd_bits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w[i] = lfsr_state[0];
		end
	endtask

	// each step ends 1 ns after a rising edge
	task automatic run_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic check_value(input int got_v, input int exp_v, input string what);
		if (got_v != exp_v) begin
			$display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, got_v, exp_v);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!cmd_valid) begin
			if (n == wait_limit) stop_run("timeout: cmd_valid never went high");
			run_cycles(1);
			n++;
		end
	endtask

	task automatic wait_words(input int count);
		int n;
		n = 0;
		while (got.size() < count) begin
			if (n == wait_limit) stop_run("timeout: expected command words never arrived");
			run_cycles(1);
			n++;
		end
	endtask

	task automatic check_counts();
		check_value(int'(drop_count), exp_drop, "drop_count");
		check_value(int'(error_count), exp_err, "error_count");
	endtask

	// spike > 0 puts a dropout mid mark and a pulse mid gap
	task automatic send_mark(input int len, input int spike);
		int hi;
		int lo;
		hi = len * TICK_DIV;
		lo = gap_ticks * TICK_DIV;
		ir_in = 1'b1;
		run_cycles(hi / 2);
		ir_in = (spike > 0) ? 1'b0 : 1'b1;
		run_cycles(spike);
		ir_in = 1'b1;
		run_cycles(hi - hi / 2 - spike);
		ir_in = 1'b0;
		run_cycles(lo / 2);
		ir_in = (spike > 0) ? 1'b1 : 1'b0;
		run_cycles(spike);
		ir_in = 1'b0;
		run_cycles(lo - lo / 2 - spike);
	endtask

	// wobble moves data marks to the window edges, +tol on even bits
	// bad_bit of -1 means every data mark is good
	task automatic send_frame(input logic [ir_rx_pkg::cmd_bits-1:0] w, input int start_len,
		input int wobble, input int bad_bit, input int spikes);
		int len;
		send_mark(start_len, (spikes != 0) ? 2 : 0);
		for (int i = 0; i < ir_rx_pkg::cmd_bits; i++) begin
			len = w[i] ? ir_rx_pkg::mark_one : ir_rx_pkg::mark_zero;
			if (wobble != 0) begin
				len = len + ((i % 2 == 0) ? ir_rx_pkg::mark_tol : -ir_rx_pkg::mark_tol);
			end
			if (i == bad_bit) len = bad_len;
			send_mark(len, (spikes != 0) ? (i % 2) + 1 : 0);
		end
	endtask

	// let the consumer take n words and compare with the sent order
	task automatic drain(input int n);
		cmd_ready = 1'b1;
		wait_words(n);
		run_cycles(2 * TICK_DIV);
		check_value(got.size(), n, "number of drained words");
		for (int k = 0; k < n; k++) begin
			check_value(int'(got[k]), int'(sent[k]), "drained word");
		end
		check_value(int'(cmd_valid), 0, "cmd_valid after drain");
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_single_frame();
		logic [ir_rx_pkg::cmd_bits-1:0] w;
		got.delete();
		cmd_ready = 1'b1;
		next_word(w);
		send_frame(w, ir_rx_pkg::mark_start, 0, -1, 0);
		wait_words(1);
		run_cycles(2 * TICK_DIV);
		check_value(got.size(), 1, "word count for one frame");
		check_value(int'(got[0]), int'(w), "single frame word");
		check_counts();
	endtask

	task automatic test_back_pressure();
		logic [ir_rx_pkg::cmd_bits-1:0] w;
		got.delete();
		sent.delete();
		cmd_ready = 1'b0;
		for (int k = 0; k < 3; k++) begin
			next_word(w);
			sent.push_back(w);
			send_frame(w, ir_rx_pkg::mark_start, 0, -1, 0);
		end
		wait_valid();
		check_value(int'(cmd_data), int'(sent[0]), "head word while stalled");
		run_cycles(TICK_DIV);
		check_value(int'(cmd_valid), 1, "cmd_valid held while stalled");
		check_value(int'(cmd_data), int'(sent[0]), "head word still held");
		drain(3);
		check_counts();
	endtask

	task automatic test_overflow();
		logic [ir_rx_pkg::cmd_bits-1:0] w;
		got.delete();
		sent.delete();
		cmd_ready = 1'b0;
		for (int k = 0; k < QUEUE_DEPTH + 2; k++) begin
			next_word(w);
			sent.push_back(w);
			send_frame(w, ir_rx_pkg::mark_start, 0, -1, 0);
		end
		exp_drop = exp_drop + 2;
		check_counts();
		// only the first QUEUE_DEPTH words were kept
		drain(QUEUE_DEPTH);
	endtask

	task automatic test_tolerance_edges();
		logic [ir_rx_pkg::cmd_bits-1:0] w;
		got.delete();
		cmd_ready = 1'b1;
		// 0x333 puts ones and zeros on both edges of their windows
		send_frame(12'h333, ir_rx_pkg::mark_start - ir_rx_pkg::mark_tol, 1, -1, 0);
		wait_words(1);
		check_value(int'(got[0]), 'h333, "frame at window edges");
		// start mark one tick too long, frame ignored silently
		next_word(w);
		send_frame(w, ir_rx_pkg::mark_start + ir_rx_pkg::mark_tol + 1, 0, -1, 0);
		run_cycles(2 * TICK_DIV);
		check_value(got.size(), 1, "word count after long start mark");
		check_counts();
		next_word(w);
		send_frame(w, ir_rx_pkg::mark_start + ir_rx_pkg::mark_tol, 0, -1, 0);
		wait_words(2);
		check_value(int'(got[1]), int'(w), "frame after long start mark");
	endtask

	task automatic test_bad_data_mark();
		logic [ir_rx_pkg::cmd_bits-1:0] w;
		got.delete();
		cmd_ready = 1'b1;
		next_word(w);
		send_frame(w, ir_rx_pkg::mark_start, 0, 5, 0);
		run_cycles(2 * TICK_DIV);
		check_value(got.size(), 0, "word count after bad data mark");
		exp_err = exp_err + 1;
		check_counts();
		next_word(w);
		send_frame(w, ir_rx_pkg::mark_start, 0, -1, 0);
		wait_words(1);
		check_value(int'(got[0]), int'(w), "frame after bad data mark");
	endtask

	task automatic test_glitch_rejection();
		logic [ir_rx_pkg::cmd_bits-1:0] w;
		got.delete();
		cmd_ready = 1'b1;
		next_word(w);
		send_frame(w, ir_rx_pkg::mark_start, 0, -1, 1);
		wait_words(1);
		check_value(int'(got[0]), int'(w), "frame with spikes");
		check_counts();
	endtask

	initial begin
		rst = 1'b1;
		ir_in = 1'b0;
		cmd_ready = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;
		check_value(int'(cmd_valid), 0, "cmd_valid after reset");
		check_counts();
		test_single_frame();
		test_back_pressure();
		test_overflow();
		test_tolerance_edges();
		test_bad_data_mark();
		test_glitch_rejection();
		$display("No errors");
		$finish;
	end

endmodule

//--- bench/ir_remote_rx_chk.sv
`timescale 1ns/1ns

module ir_remote_rx_chk (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	input logic cmd_ready,
	input logic [ir_rx_pkg::cmd_bits-1:0] cmd_data,
	input logic [ir_rx_pkg::stat_bits-1:0] drop_count,
	input logic [ir_rx_pkg::stat_bits-1:0] error_count
);

	//////////////////////////////////////////////////////////////////////
	// output handshake
	//////////////////////////////////////////////////////////////////////

	// head word frozen while the consumer stalls
	data_stable: assert property (@(posedge clock) disable iff (rst)
		(cmd_valid && !cmd_ready) |=> $stable(cmd_data))
		else $error("cmd_data changed while cmd_valid waited for cmd_ready");

	// valid never withdrawn before the transfer
	valid_hold: assert property (@(posedge clock) disable iff (rst)
		(cmd_valid && !cmd_ready) |=> cmd_valid)
		else $error("cmd_valid dropped without a transfer");

	// empty queue right out of reset
	valid_reset: assert property (@(posedge clock) rst |=> !cmd_valid)
		else $error("cmd_valid high in the cycle after reset");

	// statistics only ever grow
	counts_grow: assert property (@(posedge clock) disable iff (rst)
		(drop_count >= $past(drop_count)) && (error_count >= $past(error_count)))
		else $error("drop_count or error_count went down");

endmodule

bind ir_remote_rx ir_remote_rx_chk ir_remote_rx_chk_i (
	.clock(clock),
	.rst(rst),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.cmd_data(cmd_data),
	.drop_count(drop_count),
	.error_count(error_count)
);

//--- src/ir_remote_rx.sv
`timescale 1ns/1ns

module ir_remote_rx #(
	parameter int TICK_DIV = 1875,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic ir_in,
	output logic cmd_valid,
	input  logic cmd_ready,
	output logic [ir_rx_pkg::cmd_bits-1:0] cmd_data,
	output logic [ir_rx_pkg::stat_bits-1:0] drop_count,
	output logic [ir_rx_pkg::stat_bits-1:0] error_count
);

	// sampling tick
	logic tick;

	// filtered input level
	logic ir_level;

	// receiver to queue
	logic frame_valid;
	logic [ir_rx_pkg::cmd_bits-1:0] frame_data;
	logic frame_error;

	//////////////////////////////////////////////////////////////////////
	// front end
	//////////////////////////////////////////////////////////////////////

	sample_tick_gen #(
		.TICK_DIV(TICK_DIV)
	) sample_tick_gen_i (
		.clock(clock),
		.rst(rst),
		.tick(tick)
	);

	ir_input_filter ir_input_filter_i (
		.clock(clock),
		.rst(rst),
		.ir_in(ir_in),
		.ir_level(ir_level)
	);

	//////////////////////////////////////////////////////////////////////
	// decode and buffer
	//////////////////////////////////////////////////////////////////////

	ir_frame_receiver ir_frame_receiver_i (
		.clock(clock),
		.rst(rst),
		.tick(tick),
		.ir_level(ir_level),
		.frame_valid(frame_valid),
		.frame_data(frame_data),
		.frame_error(frame_error)
	);

	// back-pressure ends here as counted drops
	ir_command_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) ir_command_queue_i (
		.clock(clock),
		.rst(rst),
		.frame_valid(frame_valid),
		.frame_data(frame_data),
		.frame_error(frame_error),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_data(cmd_data),
		.drop_count(drop_count),
		.error_count(error_count)
	);

endmodule

//--- src/ir_command_queue.sv
`timescale 1ns/1ns

module ir_command_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic frame_valid,
	input  logic [ir_rx_pkg::cmd_bits-1:0] frame_data,
	input  logic frame_error,
	output logic cmd_valid,
	input  logic cmd_ready,
	output logic [ir_rx_pkg::cmd_bits-1:0] cmd_data,
	output logic [ir_rx_pkg::stat_bits-1:0] drop_count,
	output logic [ir_rx_pkg::stat_bits-1:0] error_count
);

	localparam int ptr_w = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int occ_w = $clog2(QUEUE_DEPTH + 1);

	// pointer wrap point, depth need not be a power of two
	localparam logic [ptr_w-1:0] last_ptr = ptr_w'(QUEUE_DEPTH - 1);
	localparam logic [occ_w-1:0] depth_occ = occ_w'(QUEUE_DEPTH);

	// word storage
	logic [ir_rx_pkg::cmd_bits-1:0] mem [QUEUE_DEPTH];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [occ_w-1:0] occ;

	logic full;
	logic push;
	logic pop;

	assign full = (occ == depth_occ);
	// a full queue drops the word even if a read happens now
	assign push = frame_valid && !full;
	assign pop = cmd_valid && cmd_ready;

	// head entry is always on the output
	assign cmd_valid = (occ != '0);
	assign cmd_data = mem[rd_ptr];

	//////////////////////////////////////////////////////////////////////
	// storage and pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= frame_data;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leave occupancy alone
			case ({push, pop})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// statistics, saturating
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			drop_count <= '0;
			error_count <= '0;
		end else begin
			if (frame_valid && full && (drop_count != '1)) begin
				drop_count <= drop_count + 1'b1;
			end
			if (frame_error && (error_count != '1)) begin
				error_count <= error_count + 1'b1;
			end
		end
	end

endmodule

//--- src/ir_frame_receiver.sv
`timescale 1ns/1ns

module ir_frame_receiver (
	input  logic clock,
	input  logic rst,
	input  logic tick,
	input  logic ir_level,
	output logic frame_valid,
	output logic [ir_rx_pkg::cmd_bits-1:0] frame_data,
	output logic frame_error
);

	localparam int cnt_w = ir_rx_pkg::mark_cnt_bits;
	localparam int idx_w = ir_rx_pkg::bit_idx_bits;

	//////////////////////////////////////////////////////////////////////
	// acceptance windows, nominal +/- tolerance
	//////////////////////////////////////////////////////////////////////

	localparam logic [cnt_w-1:0] start_lo =
		cnt_w'(ir_rx_pkg::mark_start - ir_rx_pkg::mark_tol);
	localparam logic [cnt_w-1:0] start_hi =
		cnt_w'(ir_rx_pkg::mark_start + ir_rx_pkg::mark_tol);
	localparam logic [cnt_w-1:0] one_lo =
		cnt_w'(ir_rx_pkg::mark_one - ir_rx_pkg::mark_tol);
	localparam logic [cnt_w-1:0] one_hi =
		cnt_w'(ir_rx_pkg::mark_one + ir_rx_pkg::mark_tol);
	localparam logic [cnt_w-1:0] zero_lo =
		cnt_w'(ir_rx_pkg::mark_zero - ir_rx_pkg::mark_tol);
	localparam logic [cnt_w-1:0] zero_hi =
		cnt_w'(ir_rx_pkg::mark_zero + ir_rx_pkg::mark_tol);

	// index of the final data bit
	localparam logic [idx_w-1:0] last_idx = idx_w'(ir_rx_pkg::cmd_bits - 1);

	// fsm encoding
	localparam logic [1:0] st_wait_start = 2'd0;
	localparam logic [1:0] st_wait_mark = 2'd1;
	localparam logic [1:0] st_measure = 2'd2;

	logic [1:0] state;

	// ticks seen high in the current mark
	logic [cnt_w-1:0] mark_cnt;
	logic [cnt_w-1:0] mark_inc;

	// position of the next data bit
	logic [idx_w-1:0] bit_idx;

	// window hits for the finished mark
	logic is_start;
	logic is_one;
	logic is_zero;

	// a data mark ends on this tick
	logic data_end;

	// saturating increment
	assign mark_inc = (mark_cnt == '1) ? mark_cnt : mark_cnt + 1'b1;

	assign is_start = (mark_cnt >= start_lo) && (mark_cnt <= start_hi);
	assign is_one = (mark_cnt >= one_lo) && (mark_cnt <= one_hi);
	assign is_zero = (mark_cnt >= zero_lo) && (mark_cnt <= zero_hi);

	assign data_end = tick && (state == st_measure) && !ir_level;

	//////////////////////////////////////////////////////////////////////
	// mark fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_wait_start;
			mark_cnt <= '0;
			bit_idx <= '0;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			// strobes last one cycle
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			if (tick) begin
				case (state)
					st_wait_start: begin
						if (ir_level) begin
							mark_cnt <= mark_inc;
						end else begin
							// line low: judge whatever mark came before
							// a miss here is silent, idle low counts zero
							if (is_start) begin
								state <= st_wait_mark;
							end
							mark_cnt <= '0;
							bit_idx <= '0;
						end
					end

					st_wait_mark: begin
						// gaps are not measured
						if (ir_level) begin
							mark_cnt <= cnt_w'(1);
							state <= st_measure;
						end
					end

					st_measure: begin
						if (ir_level) begin
							mark_cnt <= mark_inc;
						end else begin
							mark_cnt <= '0;
							if (is_one || is_zero) begin
								if (bit_idx == last_idx) begin
									// whole word in, hand it on
									frame_valid <= 1'b1;
									bit_idx <= '0;
									state <= st_wait_start;
								end else begin
									bit_idx <= bit_idx + 1'b1;
									state <= st_wait_mark;
								end
							end else begin
								// bad data mark drops the frame
								frame_error <= 1'b1;
								bit_idx <= '0;
								state <= st_wait_start;
							end
						end
					end

					default: begin
						state <= st_wait_start;
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// word assembly, lsb first
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (data_end && (is_one || is_zero)) begin
			// one window wins, else it is a zero
			frame_data[bit_idx] <= is_one;
		end
	end

endmodule

//--- src/ir_input_filter.sv
`timescale 1ns/1ns

module ir_input_filter (
	input  logic clock,
	input  logic rst,
	input  logic ir_in,
	output logic ir_level
);

	// first synchronizer flop, may go metastable
	logic sync_meta;

	// sample history, newest in bit 0
	// bit 0 doubles as the second synchronizer flop
	logic [2:0] hist;

	// all three samples high / all three samples low
	logic all_high;
	logic all_low;

	//////////////////////////////////////////////////////////////////////
	// synchronizer and history
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			sync_meta <= 1'b0;
			hist <= 3'b000;
		end else begin
			sync_meta <= ir_in;
			// shift in the synchronized sample
			hist <= {hist[1:0], sync_meta};
		end
	end

	assign all_high = &hist;
	assign all_low = ~|hist;

	//////////////////////////////////////////////////////////////////////
	// vote
	//////////////////////////////////////////////////////////////////////

	// level only moves once the whole history agrees
	// so a spike of one or two cycles never gets through
	always_ff @(posedge clock) begin
		if (rst) begin
			ir_level <= 1'b0;
		end else if (all_high) begin
			ir_level <= 1'b1;
		end else if (all_low) begin
			ir_level <= 1'b0;
		end
		// mixed history: hold the last level
	end

endmodule

//--- src/sample_tick_gen.sv
`timescale 1ns/1ns

module sample_tick_gen #(
	parameter int TICK_DIV = 1875
) (
	input  logic clock,
	input  logic rst,
	output logic tick
);

	// counter just wide enough for TICK_DIV-1
	localparam int cnt_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	// value loaded after reset and after every tick
	localparam logic [cnt_w-1:0] reload = cnt_w'(TICK_DIV - 1);

	// cycles left until the next tick
	logic [cnt_w-1:0] div_cnt;

	//////////////////////////////////////////////////////////////////////
	// down counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			// first tick lands TICK_DIV cycles after reset drops
			div_cnt <= reload;
			tick <= 1'b0;
		end else begin
			if (div_cnt == '0) begin
				// expired: one-cycle tick and start over
				div_cnt <= reload;
				tick <= 1'b1;
			end else begin
				div_cnt <= div_cnt - 1'b1;
				tick <= 1'b0;
			end
		end
	end

	// with TICK_DIV of 1 the counter sits at zero
	// and tick stays high, one tick per clock

endmodule

//--- src/ir_rx_pkg.sv
package ir_rx_pkg;

	//////////////////////////////////////////////////////////////////////
	// command word
	//////////////////////////////////////////////////////////////////////

	// bits per command word, sent lsb first
	localparam int cmd_bits = 12;

	// width of the bit index inside a frame
	localparam int bit_idx_bits = 4;

	//////////////////////////////////////////////////////////////////////
	// mark lengths in sample ticks
	//////////////////////////////////////////////////////////////////////

	// start mark opens a frame
	localparam int mark_start = 32;

	// data mark for a one
	localparam int mark_one = 16;

	// data mark for a zero
	localparam int mark_zero = 8;

	// allowed deviation on either side of every nominal length
	// both window ends count as inside
	localparam int mark_tol = 2;

	// mark length counter width
	// the counter saturates so a stuck-high line never looks valid
	localparam int mark_cnt_bits = 8;

	//////////////////////////////////////////////////////////////////////
	// statistics
	//////////////////////////////////////////////////////////////////////

	// drop and error counters, both saturating
	localparam int stat_bits = 8;

endpackage
